//--- source/bridge_pkg.sv
`default_nettype none

package bridge_pkg;

    // bus side
    typedef logic [63:0] addr_t;
    typedef logic [63:0] dword_t;

    // memory side
    typedef logic [31:0] word_t;
    typedef logic [15:0] half_t;
    typedef logic [21:0] sdram_addr_t;    // halfword address
    typedef logic [1:0]  byte_en_t;       // bit 1 is the high byte
    typedef logic [9:0]  ram_index_t;

    // riscv load/store width, bit 2 marks the unsigned loads
    typedef enum logic [2:0] {
        LS_B  = 3'd0,
        LS_H  = 3'd1,
        LS_W  = 3'd2,
        LS_D  = 3'd3,
        LS_BU = 3'd4,
        LS_HU = 3'd5,
        LS_WU = 3'd6
    } ls_type_t;

    // address map
    localparam addr_t RAM_BASE  = 64'h0000_0000_0000_1000;
    localparam int    RAM_WORDS = 1024;                       // 4 KB window
    localparam addr_t SDRAM_MIN = 64'h0000_0000_0100_0000;
    localparam addr_t SDRAM_MAX = 64'h0000_0000_0180_0000;  // 8 MB window

    typedef struct packed {
        addr_t    address;
        ls_type_t ls_type;
        logic     write;      // store when set
        dword_t   wdata;
    } bus_req_t;

    typedef struct packed {
        sdram_addr_t addr;
        byte_en_t    byte_en;
        half_t       wrdata;
        logic        read_en;
        logic        write_en;
    } sdram_port_t;

endpackage

`default_nettype wire

//--- source/ram_lane_port.sv
`timescale 1ns/1ps
`default_nettype none

module ram_lane_port import bridge_pkg::*; (
    input  wire           CLOCK_50,
    input  wire           KEY0,
    input  wire bus_req_t req,
    input  wire           start,
    output dword_t        data,
    output logic          finish
);

    word_t      mem [RAM_WORDS];
    ram_index_t base_index;
    ram_index_t cur_index;
    logic [1:0] offset;
    logic       second;       // upper word of a doubleword
    logic       access;
    logic [3:0] lane_we;
    word_t      store_word;

    assign base_index = req.address[11:2];
    assign offset     = req.address[1:0];
    assign cur_index  = second ? ram_index_t'(base_index + 1'b1) : base_index;
    assign access     = start | second;

    // byte lane enables, store data replicated across the lanes
    always_comb begin
        lane_we    = 4'b0000;
        store_word = req.wdata[31:0];
        if (access && req.write) begin
            case (req.ls_type)
                LS_B: begin
                    lane_we    = 4'b0001 << offset;
                    store_word = {4{req.wdata[7:0]}};
                end
                LS_H: begin
                    lane_we    = 4'b0011 << offset;   // offset is 0 or 2
                    store_word = {2{req.wdata[15:0]}};
                end
                LS_D: begin
                    lane_we = 4'b1111;
                    if (second)
                        store_word = req.wdata[63:32];
                end
                default: lane_we = 4'b1111;           // sw
            endcase
        end
    end

    always_ff @(posedge CLOCK_50) begin
        for (int b = 0; b < 4; b++) begin
            if (lane_we[b])
                mem[cur_index][8*b +: 8] <= store_word[8*b +: 8];
        end
        if (access && !req.write) begin
            if (req.ls_type != LS_D)
                data <= {32'd0, mem[cur_index] >> {offset, 3'b000}};
            else if (!second)
                data <= {32'd0, mem[cur_index]};
            else
                data[63:32] <= mem[cur_index];
        end
    end

    // doubleword takes one extra cycle
    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            second <= 1'b0;
            finish <= 1'b0;
        end else begin
            second <= start && (req.ls_type == LS_D);
            finish <= (start && (req.ls_type != LS_D)) || second;
        end
    end

endmodule

`default_nettype wire

//--- source/sdram_beat_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

module sdram_beat_sequencer import bridge_pkg::*; (
    input  wire           CLOCK_50,
    input  wire           KEY0,
    input  wire bus_req_t req,
    input  wire           start,
    output sdram_port_t   sdram,
    input  wire half_t    sdram_rddata,
    input  wire           sdram_req_wait,
    output dword_t        data,
    output logic          finish
);

    typedef enum logic [1:0] {S_IDLE, S_REQ, S_GAP} state_t;

    state_t     state;
    logic [1:0] beat;          // current halfword beat
    logic [1:0] last_beat;
    logic       byte_access;
    byte_en_t   first_be;
    logic       accept;

    assign byte_access = (req.ls_type == LS_B) || (req.ls_type == LS_BU);
    assign accept      = (state == S_REQ) && !sdram_req_wait;

    always_comb begin
        case (req.ls_type)
            LS_W, LS_WU: last_beat = 2'd1;
            LS_D:        last_beat = 2'd3;
            default:     last_beat = 2'd0;   // byte and halfword
        endcase
    end

    // even byte sits in the low lane
    assign first_be = byte_access ? (req.address[0] ? 2'b10 : 2'b01) : 2'b11;

    function automatic half_t beat_data(logic [1:0] idx);
        if (byte_access)
            return {2{req.wdata[7:0]}};
        return req.wdata[{idx, 4'b0000} +: 16];
    endfunction

    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            state  <= S_IDLE;
            beat   <= 2'd0;
            finish <= 1'b0;
            sdram  <= '0;
        end else begin
            finish <= 1'b0;
            case (state)
                S_IDLE: begin
                    if (start) begin
                        sdram.addr     <= req.address[22:1];
                        sdram.byte_en  <= first_be;
                        sdram.wrdata   <= beat_data(2'd0);
                        sdram.read_en  <= !req.write;
                        sdram.write_en <= req.write;
                        beat           <= 2'd0;
                        state          <= S_REQ;
                    end
                end
                S_REQ: begin
                    // hold everything until the controller takes the beat
                    if (accept) begin
                        sdram.read_en  <= 1'b0;
                        sdram.write_en <= 1'b0;
                        if (beat == last_beat) begin
                            finish <= 1'b1;
                            state  <= S_IDLE;
                        end else begin
                            beat  <= beat + 1'b1;
                            state <= S_GAP;
                        end
                    end
                end
                S_GAP: begin
                    // multi-beat accesses keep byte enables at 11
                    sdram.addr     <= sdram.addr + 1'b1;
                    sdram.wrdata   <= beat_data(beat);
                    sdram.read_en  <= !req.write;
                    sdram.write_en <= req.write;
                    state          <= S_REQ;
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    // low half first, byte loads land at bit 0
    always_ff @(posedge CLOCK_50) begin
        if (start) begin
            data <= '0;
        end else if (accept && !req.write) begin
            if (byte_access)
                data <= {56'd0, req.address[0] ? sdram_rddata[15:8] : sdram_rddata[7:0]};
            else
                data[{beat, 4'b0000} +: 16] <= sdram_rddata;
        end
    end

endmodule

`default_nettype wire

//--- source/bus_responder.sv
`timescale 1ns/1ps
`default_nettype none

module bus_responder import bridge_pkg::*; (
    input  wire           CLOCK_50,
    input  wire           KEY0,
    input  wire addr_t    bus_address,
    input  wire ls_type_t bus_ls_type,
    input  wire dword_t   bus_write_data,
    input  wire           bus_read_enable,
    input  wire           bus_write_enable,
    output dword_t        bus_read_data,
    output logic          bus_read_done,
    output logic          bus_write_done,
    output bus_req_t      req,
    output logic          ram_start,
    output logic          sdram_start,
    input  wire dword_t   ram_data,
    input  wire           ram_finish,
    input  wire dword_t   sdram_data,
    input  wire           sdram_finish
);

    typedef enum logic [1:0] {S_IDLE, S_DECODE, S_WAIT} state_t;

    state_t state;
    logic   request;
    logic   in_ram;
    logic   in_sdram;
    dword_t raw;

    assign request  = (state == S_IDLE) && (bus_read_enable || bus_write_enable);
    assign in_ram   = (req.address >= RAM_BASE) && (req.address < RAM_BASE + 4 * RAM_WORDS);
    assign in_sdram = (req.address >= SDRAM_MIN) && (req.address < SDRAM_MAX);
    assign raw      = ram_finish ? ram_data : sdram_data;

    function automatic dword_t extend(dword_t value, ls_type_t kind);
        case (kind)
            LS_B:    return {{56{value[7]}}, value[7:0]};
            LS_H:    return {{48{value[15]}}, value[15:0]};
            LS_W:    return {{32{value[31]}}, value[31:0]};
            LS_BU:   return {56'd0, value[7:0]};
            LS_HU:   return {48'd0, value[15:0]};
            LS_WU:   return {32'd0, value[31:0]};
            default: return value;             // ld
        endcase
    endfunction

    // requests while busy are dropped
    always_ff @(posedge CLOCK_50) begin
        if (request)
            req <= '{address: bus_address, ls_type: bus_ls_type,
                     write: bus_write_enable, wdata: bus_write_data};
    end

    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            state          <= S_IDLE;
            ram_start      <= 1'b0;
            sdram_start    <= 1'b0;
            bus_read_done  <= 1'b1;
            bus_write_done <= 1'b1;
            bus_read_data  <= '0;
        end else begin
            ram_start   <= 1'b0;
            sdram_start <= 1'b0;
            case (state)
                S_IDLE: begin
                    if (request) begin
                        if (bus_read_enable)
                            bus_read_done <= 1'b0;
                        if (bus_write_enable)
                            bus_write_done <= 1'b0;
                        state <= S_DECODE;
                    end
                end
                S_DECODE: begin
                    if (in_ram) begin
                        ram_start <= 1'b1;
                        state     <= S_WAIT;
                    end else if (in_sdram) begin
                        sdram_start <= 1'b1;
                        state       <= S_WAIT;
                    end else begin                  // unmapped, done right away
                        if (req.write) begin
                            bus_write_done <= 1'b1;
                        end else begin
                            bus_read_data <= '0;
                            bus_read_done <= 1'b1;
                        end
                        state <= S_IDLE;
                    end
                end
                S_WAIT: begin
                    if (ram_finish || sdram_finish) begin
                        if (req.write) begin
                            bus_write_done <= 1'b1;
                        end else begin
                            bus_read_data <= extend(raw, req.ls_type);
                            bus_read_done <= 1'b1;
                        end
                        state <= S_IDLE;
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- source/memory_bridge.sv
`timescale 1ns/1ps
`default_nettype none

module memory_bridge import bridge_pkg::*; (
    input  wire           CLOCK_50,
    input  wire           KEY0,
    input  wire addr_t    bus_address,
    input  wire ls_type_t bus_ls_type,
    input  wire dword_t   bus_write_data,
    input  wire           bus_read_enable,
    input  wire           bus_write_enable,
    output dword_t        bus_read_data,
    output logic          bus_read_done,
    output logic          bus_write_done,
    output sdram_port_t   sdram,
    input  wire half_t    sdram_rddata,
    input  wire           sdram_req_wait
);

    bus_req_t req;           // captured access, shared by both units
    logic     ram_start;
    logic     ram_finish;
    dword_t   ram_data;
    logic     sdram_start;
    logic     sdram_finish;
    dword_t   sdram_data;

    bus_responder u_responder (
        .CLOCK_50, .KEY0,
        .bus_address, .bus_ls_type, .bus_write_data, .bus_read_enable, .bus_write_enable,
        .bus_read_data, .bus_read_done, .bus_write_done,
        .req, .ram_start, .sdram_start,
        .ram_data, .ram_finish, .sdram_data, .sdram_finish
    );

    ram_lane_port u_ram (
        .CLOCK_50, .KEY0, .req, .start(ram_start), .data(ram_data), .finish(ram_finish)
    );

    sdram_beat_sequencer u_sdram_seq (
        .CLOCK_50, .KEY0, .req, .start(sdram_start),
        .sdram, .sdram_rddata, .sdram_req_wait,
        .data(sdram_data), .finish(sdram_finish)
    );

endmodule

`default_nettype wire

//--- verification/sdram_model.sv
`timescale 1ns/1ps
`default_nettype none

module sdram_model import bridge_pkg::*; (
    input  wire              CLOCK_50,
    input  wire sdram_port_t sdram,
    input  wire              stall,        // random back-pressure from the testbench
    output half_t            sdram_rddata,
    output logic             sdram_req_wait
);

    half_t       mem [sdram_addr_t];
    sdram_port_t beats [$];                // accepted beats of the current access
    sdram_port_t last;
    logic        held = 1'b0;
    int unsigned writes = 0;
    int          hold_errors = 0;

    // unwritten halfwords read back a pattern of the full address
    function automatic half_t read_half(sdram_addr_t a);
        if (mem.exists(a))
            return mem[a];
        return half_t'(a ^ (a >> 11));
    endfunction

    assign sdram_req_wait = stall;

    always @(sdram, stall, writes) begin
        sdram_rddata = (sdram.read_en && !stall) ? read_half(sdram.addr) : 16'h0000;
    end

    always @(posedge CLOCK_50) begin
        half_t h;
        // a stalled beat must come back unchanged
        if (held && sdram != last) begin
            hold_errors++;
            $display("error sdram changed under wait: got %h expected %h", sdram, last);
        end
        if ((sdram.read_en || sdram.write_en) && !stall) begin
            beats.push_back(sdram);
            if (sdram.write_en) begin
                h = read_half(sdram.addr);
                if (sdram.byte_en[0])
                    h[7:0] = sdram.wrdata[7:0];
                if (sdram.byte_en[1])
                    h[15:8] = sdram.wrdata[15:8];
                mem[sdram.addr] = h;
                writes++;
            end
        end
        held = (sdram.read_en || sdram.write_en) && stall;
        last = sdram;
    end

endmodule

`default_nettype wire

//--- verification/tb_memory_bridge.sv
`timescale 1ns/1ps
`default_nettype none

module tb_memory_bridge import bridge_pkg::*; ();

    localparam logic [31:0] SEED        = 32'hc76f6d29;
    localparam int          OPS         = 400;
    localparam int          PREFILL     = 64;            // doubleword stores per window
    localparam int          REGION      = 512;           // bytes exercised per window
    localparam int          WATCHDOG_NS = OPS * 64 * 20;
    localparam addr_t       RAM_AREA    = RAM_BASE + 64'h0E00;    // top of the RAM window
    localparam addr_t       SD_AREA     = SDRAM_MAX - REGION;

    logic        CLOCK_50 = 1'b0;
    logic        KEY0;
    addr_t       bus_address;
    ls_type_t    bus_ls_type;
    dword_t      bus_write_data;
    logic        bus_read_enable;
    logic        bus_write_enable;
    dword_t      bus_read_data;
    logic        bus_read_done;
    logic        bus_write_done;
    sdram_port_t sdram;
    half_t       sdram_rddata;
    logic        sdram_req_wait;
    logic        stall;
    logic [31:0] stim_rng;
    logic [31:0] wait_rng;
    logic [7:0]  ram_ref [REGION];
    logic [7:0]  sd_ref [REGION];
    int          checks;
    int          errors;

    memory_bridge DUT (.*);

    sdram_model model (.CLOCK_50, .sdram, .stall, .sdram_rddata, .sdram_req_wait);

    always #10 CLOCK_50 = ~CLOCK_50;

    // wait is high in about one cycle of four
    always @(posedge CLOCK_50) begin
        #2;
        wait_rng = xorshift(wait_rng);
        stall    = (wait_rng[1:0] == 2'b00);
    end

    initial begin
        #(WATCHDOG_NS);
        $display("timeout: the run did not finish within %0d ns", WATCHDOG_NS);
        $display("SOME TESTS FAILED");
        $finish;
    end

    function automatic logic [31:0] xorshift(logic [31:0] x);
        x ^= x << 13;
        x ^= x >> 17;
        x ^= x << 5;
        return x;
    endfunction

    function automatic logic [31:0] next_random();
        stim_rng = xorshift(stim_rng);
        return stim_rng;
    endfunction

    function automatic addr_t unmapped_address(logic [2:0] k);
        case (k)
            3'd0:    return 64'h0;
            3'd1:    return RAM_BASE - 8;
            3'd2:    return RAM_BASE + 4 * RAM_WORDS;
            3'd3:    return SDRAM_MIN - 8;
            3'd4:    return SDRAM_MAX;
            3'd5:    return 64'h8000_0000;
            3'd6:    return 64'hFFFF_FFFF_FFFF_FFF8;
            default: return 64'h0100_0000_0000_1E00;   // high bits over the RAM area
        endcase
    endfunction

    // little endian gather, then sign extension for lb/lh/lw
    function automatic dword_t reference_load(logic in_ram, int off, ls_type_t t);
        int     n;
        dword_t v;
        n = 1 << t[1:0];
        v = '0;
        for (int i = n - 1; i >= 0; i--)
            v = (v << 8) | (in_ram ? ram_ref[off + i] : sd_ref[off + i]);
        if (!t[2] && n < 8)
            v = dword_t'($signed(v << (64 - 8 * n)) >>> (64 - 8 * n));
        return v;
    endfunction

    task automatic store_reference(input logic in_ram, input int off, input ls_type_t t,
                                   input dword_t d);
        for (int i = 0; i < (1 << t[1:0]); i++) begin
            if (in_ram)
                ram_ref[off + i] = d[8*i +: 8];
            else
                sd_ref[off + i] = d[8*i +: 8];
        end
    endtask

    task automatic check_beats(input addr_t a, input ls_type_t t, input logic wr, input dword_t d);
        int          n;
        byte_en_t    be;
        half_t       wd;
        sdram_port_t b;
        n  = (t[1:0] == 2'd3) ? 4 : (t[1:0] == 2'd2) ? 2 : 1;
        be = (t[1:0] != 2'd0) ? 2'b11 : (a[0] ? 2'b10 : 2'b01);
        checks++;
        if (model.beats.size() != n) begin
            errors++;
            $display("error sdram beat count at %h: got %h expected %h",
                     a, model.beats.size(), n);
            return;
        end
        for (int i = 0; i < n; i++) begin
            b  = model.beats[i];
            wd = (t[1:0] == 2'd0) ? {2{d[7:0]}} : d[16*i +: 16];
            checks++;
            if (b.addr != sdram_addr_t'(a[22:1] + i) || b.byte_en != be ||
                b.write_en != wr || (wr && b.wrdata != wd)) begin
                errors++;
                $display("error sdram beat %0d at %h: got %h %h %h %h expected %h %h %h %h",
                         i, a, b.addr, b.byte_en, b.write_en, b.wrdata,
                         sdram_addr_t'(a[22:1] + i), be, wr, wd);
            end
        end
    endtask

    // one request pulse, then wait for the done level to come back
    task automatic bus_access(input addr_t a, input ls_type_t t, input logic wr,
                              input dword_t d, output dword_t q);
        model.beats.delete();
        bus_address      = a;
        bus_ls_type      = t;
        bus_write_data   = d;
        bus_read_enable  = !wr;
        bus_write_enable = wr;
        @(posedge CLOCK_50);
        #2;
        bus_read_enable  = 1'b0;
        bus_write_enable = 1'b0;
        checks++;
        if (wr && bus_write_done !== 1'b0) begin
            errors++;
            $display("error bus_write_done after the request at %h: got %h expected %h",
                     a, bus_write_done, 1'b0);
        end
        if (!wr && bus_read_done !== 1'b0) begin
            errors++;
            $display("error bus_read_done after the request at %h: got %h expected %h",
                     a, bus_read_done, 1'b0);
        end
        while ((wr ? bus_write_done : bus_read_done) !== 1'b1) begin
            @(posedge CLOCK_50);
            #2;
        end
        q = bus_read_data;
    endtask

    task automatic random_op();
        logic [31:0] r;
        logic [31:0] r2;
        logic        wr;
        ls_type_t    t;
        int          off;
        addr_t       a;
        dword_t      d;
        dword_t      q;
        dword_t      expected;
        r   = next_random();
        r2  = next_random();
        wr  = r[4];
        t   = wr ? ls_type_t'(r[6:5]) : ls_type_t'(r[7:5] % 3'd7);
        off = int'(r2[8:0]) & ~((1 << t[1:0]) - 1);    // natural alignment
        d   = {next_random(), next_random()};
        if (r[3:0] < 4'd7)
            a = RAM_AREA + off;
        else if (r[3:0] < 4'd14)
            a = SD_AREA + off;
        else
            a = unmapped_address(r2[31:29]);
        bus_access(a, t, wr, d, q);
        if (r[3:0] >= 4'd7 && r[3:0] < 4'd14) begin
            check_beats(a, t, wr, d);
        end else begin
            checks++;
            if (model.beats.size() != 0) begin
                errors++;
                $display("error sdram beat count at %h: got %h expected %h",
                         a, model.beats.size(), 0);
            end
        end
        if (wr) begin
            if (r[3:0] < 4'd14)
                store_reference(r[3:0] < 4'd7, off, t, d);
        end else begin
            expected = (r[3:0] < 4'd14) ? reference_load(r[3:0] < 4'd7, off, t) : '0;
            checks++;
            if (q !== expected) begin
                errors++;
                $display("error bus_read_data at %h type %s: got %h expected %h",
                         a, t.name(), q, expected);
            end
        end
    endtask

    initial begin
        dword_t d;
        dword_t q;
        stim_rng         = SEED;
        wait_rng         = ~SEED;
        stall            = 1'b0;
        checks           = 0;
        errors           = 0;
        KEY0             = 1'b0;
        bus_address      = '0;
        bus_ls_type      = LS_B;
        bus_write_data   = '0;
        bus_read_enable  = 1'b0;
        bus_write_enable = 1'b0;
        repeat (10) @(posedge CLOCK_50);
        #2;
        KEY0 = 1'b1;

        checks += 4;
        if (bus_read_data !== '0) begin
            errors++;
            $display("error bus_read_data after reset: got %h expected %h", bus_read_data, 64'h0);
        end
        if (bus_read_done !== 1'b1) begin
            errors++;
            $display("error bus_read_done after reset: got %h expected %h", bus_read_done, 1'b1);
        end
        if (bus_write_done !== 1'b1) begin
            errors++;
            $display("error bus_write_done after reset: got %h expected %h",
                     bus_write_done, 1'b1);
        end
        if (sdram.read_en !== 1'b0 || sdram.write_en !== 1'b0) begin
            errors++;
            $display("error sdram enables after reset: got %h %h expected %h %h",
                     sdram.read_en, sdram.write_en, 1'b0, 1'b0);
        end

        // both windows get known contents first
        for (int i = 0; i < PREFILL; i++) begin
            d = {next_random(), next_random()};
            bus_access(RAM_AREA + 8 * i, LS_D, 1'b1, d, q);
            store_reference(1'b1, 8 * i, LS_D, d);
            d = {next_random(), next_random()};
            bus_access(SD_AREA + 8 * i, LS_D, 1'b1, d, q);
            check_beats(SD_AREA + 8 * i, LS_D, 1'b1, d);
            store_reference(1'b0, 8 * i, LS_D, d);
        end

        repeat (OPS - 2 * PREFILL) random_op();

        $display("checks %0d, errors %0d, held beat errors %0d",
                 checks, errors, model.hold_errors);
        if (errors == 0 && model.hold_errors == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- compile.f
source/bridge_pkg.sv
source/ram_lane_port.sv
source/sdram_beat_sequencer.sv
source/bus_responder.sv
source/memory_bridge.sv
verification/sdram_model.sv
verification/tb_memory_bridge.sv

//--- Bender.yml
package:
  name: memory_bridge

sources:
  - source/bridge_pkg.sv
  - source/ram_lane_port.sv
  - source/sdram_beat_sequencer.sv
  - source/bus_responder.sv
  - source/memory_bridge.sv
  - target: test
    files:
      - verification/sdram_model.sv
      - verification/tb_memory_bridge.sv
